// ==== logic/fetch_pkg.sv ====
package fetch_pkg;

    // a word is a branch when its top two bits equal this major code.
    localparam logic [1:0] BRANCH_MAJOR = 2'b01;

    // writes to r0 are discarded, so they never create a dependency.
    localparam logic [4:0] REG_ZERO = 5'd0;

    // byte distance between the two instructions of one bundle.
    localparam logic [31:0] INST_BYTES = 32'd4;

    // one instruction word seen as a three-register ALU word or as a branch word.
    typedef union packed {
        struct packed {
            logic [16:0] opcode;
            logic [4:0]  rk;
            logic [4:0]  rj;
            logic [4:0]  rd;
        } reg3;
        struct packed {
            logic [5:0]  opcode;
            logic [15:0] offs16;
            logic [4:0]  rj;
            logic [4:0]  rd;
        } branch;
    } inst_word_u;

    // cache reply, the lower word is the older instruction.
    typedef struct packed {
        logic [31:0] pc;
        logic [63:0] inst;
        logic        two_valid;
        logic [1:0]  plv;
        logic [15:0] excp_arg;
    } fetch_bundle_t;

    // one predecoded instruction as held in the queue.
    typedef struct packed {
        logic [31:0] pc;
        inst_word_u  inst;
        logic [1:0]  plv;
        logic [15:0] excp_arg;
        logic        is_branch;
    } fetch_entry_t;

    // the pair handed to decode each cycle.
    typedef struct packed {
        fetch_entry_t slot0;
        fetch_entry_t slot1;
        logic         valid0;
        logic         valid1;
    } issue_pair_t;

endpackage

// ==== logic/fetch_predecode.sv ====
module fetch_predecode
    import fetch_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    input  logic          flush,
    input  logic          fetch_valid,
    input  fetch_bundle_t fetch_bundle,
    input  logic          fetch_stall,
    output fetch_entry_t  enq_entry0,
    output fetch_entry_t  enq_entry1,
    output logic [1:0]    enq_count
);

    logic         accept;
    inst_word_u   word0;
    inst_word_u   word1;
    fetch_entry_t entry0;
    fetch_entry_t entry1;

    // the cache only presents a bundle while the stall is low, but the
    // acceptance is still qualified here so a late bundle is never taken.
    assign accept = fetch_valid && !fetch_stall;

    assign word0 = fetch_bundle.inst[31:0];
    assign word1 = fetch_bundle.inst[63:32];

    // entry0 carries the exception argument of the whole bundle.
    always_comb begin
        entry0.pc        = fetch_bundle.pc;
        entry0.inst      = word0;
        entry0.plv       = fetch_bundle.plv;
        entry0.excp_arg  = fetch_bundle.excp_arg;
        entry0.is_branch = (word0.branch.opcode[5:4] == BRANCH_MAJOR);
    end

    // the second slot never reports an exception of its own.
    always_comb begin
        entry1.pc        = fetch_bundle.pc + INST_BYTES;
        entry1.inst      = word1;
        entry1.plv       = fetch_bundle.plv;
        entry1.excp_arg  = 16'h0000;
        entry1.is_branch = (word1.branch.opcode[5:4] == BRANCH_MAJOR);
    end

    // the count is the only control state of this stage.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            enq_count <= 2'd0;
        end else if (flush || !accept) begin
            enq_count <= 2'd0;
        end else if (fetch_bundle.two_valid) begin
            enq_count <= 2'd2;
        end else begin
            enq_count <= 2'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            enq_entry0 <= entry0;
            enq_entry1 <= entry1;
        end
    end

endmodule

// ==== logic/fetch_queue.sv ====
module fetch_queue
    import fetch_pkg::*;
#(
    parameter int QUEUE_DEPTH = 16
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         flush,
    input  fetch_entry_t                 enq_entry0,
    input  fetch_entry_t                 enq_entry1,
    input  logic [1:0]                   enq_count,
    input  logic [1:0]                   deq_count,
    output fetch_entry_t                 head0,
    output fetch_entry_t                 head1,
    output logic [$clog2(QUEUE_DEPTH):0] occupancy,
    output logic                         fetch_stall
);

    localparam int AW = $clog2(QUEUE_DEPTH);

    // two entries sit in the predecode register and two more may be
    // accepted in the same cycle, so four slots must stay free.
    localparam int STALL_MARGIN = 4;

    fetch_entry_t  mem [QUEUE_DEPTH];

    logic [AW-1:0] head_ptr;
    logic [AW-1:0] tail_ptr;
    logic [AW-1:0] head_ptr_inc;
    logic [AW-1:0] tail_ptr_inc;
    logic [AW:0]   count;
    logic [AW:0]   count_next;
    logic [AW:0]   free_slots;
    logic          do_enq0;
    logic          do_enq1;

    assign do_enq0 = (enq_count != 2'd0);
    assign do_enq1 = (enq_count == 2'd2);

    // the depth is a power of two, so the pointers wrap on their own.
    assign head_ptr_inc = head_ptr + 1'b1;
    assign tail_ptr_inc = tail_ptr + 1'b1;

    assign count_next = count + (AW + 1)'(enq_count) - (AW + 1)'(deq_count);

    assign free_slots  = (AW + 1)'(QUEUE_DEPTH) - count;
    assign fetch_stall = (free_slots < (AW + 1)'(STALL_MARGIN));

    assign occupancy = count;

    // head1 is only meaningful when at least two entries are held.
    assign head0 = mem[head_ptr];
    assign head1 = mem[head_ptr_inc];

    // entry0 always goes to the tail, entry1 to the slot after it.
    always_ff @(posedge clk) begin
        if (do_enq0) begin
            mem[tail_ptr] <= enq_entry0;
        end
        if (do_enq1) begin
            mem[tail_ptr_inc] <= enq_entry1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tail_ptr <= '0;
        end else if (flush) begin
            tail_ptr <= '0;
        end else begin
            tail_ptr <= tail_ptr + AW'(enq_count);
        end
    end

    // the select stage never asks for more than it sees, so the head
    // cannot pass the tail.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head_ptr <= '0;
        end else if (flush) begin
            head_ptr <= '0;
        end else begin
            head_ptr <= head_ptr + AW'(deq_count);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (flush) begin
            count <= '0;
        end else begin
            count <= count_next;
        end
    end

endmodule

// ==== logic/issue_pair_select.sv ====
module issue_pair_select
    import fetch_pkg::*;
#(
    parameter int QUEUE_DEPTH = 16
) (
    input  fetch_entry_t                 head0,
    input  fetch_entry_t                 head1,
    input  logic [$clog2(QUEUE_DEPTH):0] occupancy,
    input  logic                         decode_stall,
    output issue_pair_t                  issue,
    output logic [1:0]                   deq_count
);

    localparam int OW = $clog2(QUEUE_DEPTH) + 1;

    logic has_one;
    logic has_two;
    logic rd_hit;
    logic pair_ok;
    logic valid0;
    logic valid1;

    assign has_one = (occupancy >= OW'(1));
    assign has_two = (occupancy >= OW'(2));

    // the second instruction reads a register the first one writes.
    assign rd_hit = (head1.inst.reg3.rj == head0.inst.reg3.rd) ||
                    (head1.inst.reg3.rk == head0.inst.reg3.rd);

    // a branch in slot0 always issues alone, since the next word may
    // not be on the taken path.
    assign pair_ok = !head0.is_branch &&
                     (!rd_hit || (head0.inst.reg3.rd == REG_ZERO));

    assign valid0 = has_one && !decode_stall;
    assign valid1 = has_two && !decode_stall && pair_ok;

    always_comb begin
        issue.slot0  = head0;
        issue.slot1  = head1;
        issue.valid0 = valid0;
        issue.valid1 = valid1;
    end

    // valid1 never rises without valid0, so this is 0, 1 or 2.
    assign deq_count = {1'b0, valid0} + {1'b0, valid1};

endmodule

// ==== logic/fetch_frontend_top.sv ====
module fetch_frontend_top
    import fetch_pkg::*;
#(
    parameter int QUEUE_DEPTH = 16
) (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          flush,
    input  logic          fetch_valid,
    input  fetch_bundle_t fetch_bundle,
    output logic          fetch_stall,
    input  logic          decode_stall,
    output issue_pair_t   issue
);

    fetch_entry_t                 enq_entry0;
    fetch_entry_t                 enq_entry1;
    logic [1:0]                   enq_count;
    fetch_entry_t                 head0;
    fetch_entry_t                 head1;
    logic [$clog2(QUEUE_DEPTH):0] occupancy;
    logic [1:0]                   deq_count;

    fetch_predecode u_predecode (
        .clk          (clk),
        .rst_n        (rst_n),
        .flush        (flush),
        .fetch_valid  (fetch_valid),
        .fetch_bundle (fetch_bundle),
        .fetch_stall  (fetch_stall),
        .enq_entry0   (enq_entry0),
        .enq_entry1   (enq_entry1),
        .enq_count    (enq_count)
    );

    fetch_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_queue (
        .clk         (clk),
        .rst_n       (rst_n),
        .flush       (flush),
        .enq_entry0  (enq_entry0),
        .enq_entry1  (enq_entry1),
        .enq_count   (enq_count),
        .deq_count   (deq_count),
        .head0       (head0),
        .head1       (head1),
        .occupancy   (occupancy),
        .fetch_stall (fetch_stall)
    );

    issue_pair_select #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_issue_select (
        .head0        (head0),
        .head1        (head1),
        .occupancy    (occupancy),
        .decode_stall (decode_stall),
        .issue        (issue),
        .deq_count    (deq_count)
    );

endmodule

// ==== testbench/tb_fetch_model.svh ====
`ifndef TB_FETCH_MODEL_SVH
`define TB_FETCH_MODEL_SVH

// a word is a branch when its two top bits carry the branch major code.
function automatic logic word_is_branch(input logic [31:0] word);
    return (word[31:30] == BRANCH_MAJOR);
endfunction

// expected queue entry for one instruction word.
function automatic fetch_entry_t make_entry(
    input logic [31:0] pc,
    input logic [31:0] word,
    input logic [1:0]  plv,
    input logic [15:0] excp_arg
);
    fetch_entry_t e;
    e.pc        = pc;
    e.inst      = word;
    e.plv       = plv;
    e.excp_arg  = excp_arg;
    e.is_branch = word_is_branch(word);
    return e;
endfunction

// branch offsets count words, so offs16 in bits 25:10 is shifted by two.
function automatic logic [31:0] branch_target(input logic [31:0] pc, input logic [31:0] word);
    return pc + {{14{word[25]}}, word[25:10], 2'b00};
endfunction

// two words may issue together unless the first is a branch or the second
// reads a nonzero register that the first one writes.
function automatic logic can_pair(input fetch_entry_t e0, input fetch_entry_t e1);
    logic [31:0] w0;
    logic [31:0] w1;
    logic [4:0]  rd0;
    w0  = e0.inst;
    w1  = e1.inst;
    rd0 = w0[4:0];
    if (word_is_branch(w0)) begin
        return 1'b0;
    end
    return (rd0 == 5'd0) || ((w1[9:5] != rd0) && (w1[14:10] != rd0));
endfunction

function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

`endif

// ==== testbench/tb_fetch_frontend.sv ====
module tb_fetch_frontend
    import fetch_pkg::*;
;

    localparam int QUEUE_DEPTH = 16;
    localparam int FIELDS = 7;
    localparam int MAX_LINES = 64;

    logic          clk;
    logic          rst_n;
    logic          flush;
    logic          fetch_valid;
    fetch_bundle_t fetch_bundle;
    logic          fetch_stall;
    logic          decode_stall;
    issue_pair_t   issue;

    logic [31:0]   stim [FIELDS * MAX_LINES];
    fetch_entry_t  model_q [$];
    int            staged;
    int            errors;
    int            checks;
    logic          timed_out;

    `include "tb_fetch_model.svh"

    fetch_frontend_top #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) uut (
        .clk          (clk),
        .rst_n        (rst_n),
        .flush        (flush),
        .fetch_valid  (fetch_valid),
        .fetch_bundle (fetch_bundle),
        .fetch_stall  (fetch_stall),
        .decode_stall (decode_stall),
        .issue        (issue)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // fully stalled phases of 32 cycles alternate with mostly-free ones so the queue fills.
    initial begin
        logic [31:0] rng;
        int          cyc;
        rng = 32'd18314;
        cyc = 0;
        decode_stall = 1'b0;
        forever begin
            @(posedge clk);
            rng = xorshift32(rng);
            cyc++;
            if (cyc[5]) begin
                decode_stall <= 1'b1;
            end else begin
                decode_stall <= (rng[1:0] == 2'b00);
            end
        end
    end

    task automatic compare_slot(input fetch_entry_t got, input string name);
        fetch_entry_t exp;
        assert (model_q.size() != 0) else begin
            $display("%s issued while no entry was pending", name);
            errors++;
        end
        if (model_q.size() != 0) begin
            exp = model_q.pop_front();
            checks++;
            assert (got.pc == exp.pc) else begin
                $display("FAIL %s.pc got %h expected %h", name, got.pc, exp.pc);
                errors++;
            end
            assert (got.inst == exp.inst) else begin
                $display("FAIL %s.inst got %h expected %h", name, got.inst, exp.inst);
                errors++;
            end
            assert (got.plv == exp.plv) else begin
                $display("FAIL %s.plv got %h expected %h", name, got.plv, exp.plv);
                errors++;
            end
            assert (got.excp_arg == exp.excp_arg) else begin
                $display("FAIL %s.excp_arg got %h expected %h", name, got.excp_arg,
                         exp.excp_arg);
                errors++;
            end
            assert (got.is_branch == exp.is_branch) else begin
                $display("FAIL %s.is_branch got %h expected %h", name, got.is_branch,
                         exp.is_branch);
                errors++;
            end
            if (exp.is_branch) begin
                $display("branch at %h target %h", exp.pc, branch_target(exp.pc, exp.inst));
            end
        end
    endtask

    // issue is combinational from the queue head, so it is sampled mid-cycle.
    initial begin
        int   vis;
        logic exp_v0;
        logic exp_v1;
        logic exp_stall;
        forever begin
            @(negedge clk);
            if (rst_n) begin
                // entries accepted at the last edge still sit in the predecode register.
                vis       = model_q.size() - staged;
                staged    = 0;
                exp_v0    = (vis >= 1) && !decode_stall;
                exp_v1    = (vis >= 2) && !decode_stall && can_pair(model_q[0], model_q[1]);
                exp_stall = (vis > QUEUE_DEPTH - 4);
                assert (vis <= QUEUE_DEPTH) else begin
                    $display("queue holds %0d entries, more than its depth", vis);
                    errors++;
                end
                assert (fetch_stall == exp_stall) else begin
                    $display("FAIL fetch_stall got %h expected %h", fetch_stall, exp_stall);
                    errors++;
                end
                assert (issue.valid0 == exp_v0) else begin
                    $display("FAIL valid0 got %h expected %h", issue.valid0, exp_v0);
                    errors++;
                end
                assert (issue.valid1 == exp_v1) else begin
                    $display("FAIL valid1 got %h expected %h", issue.valid1, exp_v1);
                    errors++;
                end
                if (issue.valid0) begin
                    compare_slot(issue.slot0, "slot0");
                end
                if (issue.valid1) begin
                    compare_slot(issue.slot1, "slot1");
                end
            end
        end
    end

    task automatic wait_stall_low();
        int n;
        n = 0;
        @(negedge clk);
        while (fetch_stall && !timed_out) begin
            @(negedge clk);
            n++;
            if (n > 1000) begin
                $display("fetch_stall stayed high for 1000 cycles");
                errors++;
                timed_out = 1'b1;
            end
        end
    endtask

    task automatic push_expected(input fetch_bundle_t b);
        model_q.push_back(make_entry(b.pc, b.inst[31:0], b.plv, b.excp_arg));
        if (b.two_valid) begin
            model_q.push_back(make_entry(b.pc + 32'd4, b.inst[63:32], b.plv, 16'h0000));
        end
        staged = b.two_valid ? 2 : 1;
    endtask

    task automatic send_bundle(input fetch_bundle_t b);
        int   tries;
        logic taken;
        tries = 0;
        taken = 1'b0;
        while (!taken && !timed_out) begin
            wait_stall_low();
            @(posedge clk);
            fetch_valid  <= 1'b1;
            fetch_bundle <= b;
            @(negedge clk);
            taken = !fetch_stall;
            @(posedge clk);
            fetch_valid <= 1'b0;
            if (taken) begin
                push_expected(b);
            end
            tries++;
            if (tries > 50) begin
                $display("bundle at pc %h was never accepted", b.pc);
                errors++;
                timed_out = 1'b1;
            end
        end
    endtask

    task automatic flush_frontend();
        @(posedge clk);
        flush       <= 1'b1;
        fetch_valid <= 1'b0;
        @(posedge clk);
        flush <= 1'b0;
        model_q.delete();
        @(negedge clk);
        assert (!issue.valid0 && !issue.valid1) else begin
            $display("FAIL flush valid0 %h valid1 %h expected 0", issue.valid0,
                     issue.valid1);
            errors++;
        end
    endtask

    initial begin
        fetch_bundle_t b;
        int            line;
        int            n;
        errors       = 0;
        checks       = 0;
        staged       = 0;
        timed_out    = 1'b0;
        rst_n        = 1'b0;
        flush        = 1'b0;
        fetch_valid  = 1'b0;
        fetch_bundle = '0;
        $readmemh("testbench/fetch_input.txt", stim);
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        assert (!fetch_stall && !issue.valid0 && !issue.valid1) else begin
            $display("FAIL reset fetch_stall %h valid0 %h valid1 %h expected 0",
                     fetch_stall, issue.valid0, issue.valid1);
            errors++;
        end
        line = 0;
        while (line < MAX_LINES && stim[line * FIELDS] != 32'hffffffff && !timed_out) begin
            b.pc        = stim[line * FIELDS];
            b.inst      = {stim[line * FIELDS + 2], stim[line * FIELDS + 1]};
            b.two_valid = stim[line * FIELDS + 3][0];
            b.plv       = stim[line * FIELDS + 4][1:0];
            b.excp_arg  = stim[line * FIELDS + 5][15:0];
            if (stim[line * FIELDS + 6][0]) begin
                flush_frontend();
            end
            send_bundle(b);
            line++;
        end
        n = 0;
        while (model_q.size() != 0 && n <= 2000) begin
            @(negedge clk);
            n++;
        end
        assert (model_q.size() == 0) else begin
            $display("%0d entries were never issued", model_q.size());
            errors++;
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== testbench/fetch_input.txt ====
// pc word0 word1 two_valid plv excp_arg flush, all hex.
// word1 is ignored when two_valid is 0; flush empties the front end before the bundle.
// a line with pc ffffffff ends the stimulus.
1c000000 00100445 00100ca6 1 0 0000 0
1c000008 00100440 00100007 1 0 0000 0
1c000010 4c000020 00100445 1 0 0012 0
1c000018 00100445 58001405 1 3 0000 0
1c000020 28c00084 8a000421 1 1 00a5 0
1c000028 00100ca6 00000000 0 1 0000 0
1c000030 00100007 00100ca6 1 2 0100 0
1c000038 6bfffc00 00100445 1 0 0000 0
1c000040 00100445 00100445 1 0 0003 0
1c000048 8a000421 28c00084 1 3 0000 0
1c000050 00100ca6 00100ca6 1 0 0000 0
1c000058 54000400 00000000 0 0 7f00 0
1c000060 00100440 00100445 1 1 0000 0
1c000068 00100445 00100ca6 1 1 0040 0
1c000070 02c00421 02c00842 1 2 0000 0
1c000078 4c000020 4c000020 1 0 0000 0
1c000080 00100007 00000000 0 0 0000 0
1c000088 28c00084 00100445 1 3 0001 0
2c000000 00100445 00100ca6 1 0 0000 1
2c000008 58001405 00100440 1 0 0000 0
2c000010 00100ca6 8a000421 1 2 00ff 0
2c000018 00100445 00000000 0 2 0000 0
2c000020 6bfffc00 28c00084 1 1 0000 0
2c000028 00100440 00100007 1 1 0020 0
2c000030 02c00421 00100ca6 1 0 0000 0
2c000038 00100445 00100445 1 3 0000 0
2c000040 54000400 00100445 1 0 1234 0
2c000048 00100ca6 00100445 1 0 0000 0
3c000000 4c000020 00000000 0 0 0000 1
3c000004 00100445 00100ca6 1 1 0000 0
3c00000c 28c00084 02c00842 1 2 0008 0
3c000014 00100007 00100440 1 3 0000 0
3c00001c 8a000421 58001405 1 0 0000 0
3c000024 00100445 00000000 0 0 0000 0
3c000028 00100ca6 00100ca6 1 1 0000 0
3c000030 00100440 00100445 1 2 0fff 0
ffffffff 00000000 00000000 0 0 0000 0

// ==== tb.f ====
+incdir+testbench
logic/fetch_pkg.sv
logic/fetch_predecode.sv
logic/fetch_queue.sv
logic/issue_pair_select.sv
logic/fetch_frontend_top.sv
testbench/tb_fetch_frontend.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Compile and run the fetch front end testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_fetch_frontend \
    -f tb.f \
    -o sim_fetch_frontend
if [ $? -ne 0 ]; then
    echo "compilation failed"
    exit 1
fi

output="$(./obj_dir/sim_fetch_frontend)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qF "*** TEST PASSED ***"; then
    exit 0
fi

echo "pass message not found"
exit 1
